//--- uart_top.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_wb_regs.sv
hdl/uart_fifo.sv
hdl/uart_baud_gen.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
verification/tb_clock_gen.sv
verification/uart_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the UART testbench with Verilator and runs it.
# The exit status of the simulation is the verdict.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f uart_top.f \
  --top-module uart_top_tb \
  -o uart_top_tb

./obj_dir/uart_top_tb

//--- verification/uart_top_tb.sv
`include "uart_cfg.svh"

module uart_top_tb
  import uart_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 4;
  localparam int MAX_DIV    = 5;
  localparam int TX_FRAMES  = 12;
  localparam int BURST_LEN  = `UART_FIFO_DEPTH + 4;
  localparam int RX_FRAMES  = 14;
  localparam int FRAME_BITS = 12;
  localparam int WD_MARGIN  = 50000;
  localparam int WD_CLOCKS  = (TX_FRAMES + BURST_LEN + RX_FRAMES) * FRAME_BITS
                              * MAX_DIV * `UART_OVERSAMPLE + WD_MARGIN;
  localparam int WB_TIMEOUT = 4096;

  logic        clk;
  logic        reset;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        rx_line;
  logic        tx_line;
  logic [31:0] rng_state = 32'd8056;
  int          bit_clocks;
  logic        cur_parity;
  uart_byte_t  mon_q[$];
  uart_byte_t  exp_q[$];

  tb_clock_gen u_clock_gen (
    .clk  (clk),
    .reset(reset)
  );

  uart_top u_dut (
    .clk   (clk),
    .reset (reset),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp),
    .rx    (rx_line),
    .tx    (tx_line)
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic report_failure();
    $display("TB FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp) begin
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_status(input string name, input uart_status_t exp,
                              input uart_status_t act);
    if (act !== exp) begin
      $display("** Error [%s] expected status %b, actual %b", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_ctrl(input string name, input uart_ctrl_t exp, input uart_ctrl_t act);
    if (act !== exp) begin
      $display("** Error [%s] expected parity %b divisor %0d, actual parity %b divisor %0d",
               name, exp.parity_enable, exp.divisor, act.parity_enable, act.divisor);
      report_failure();
    end
  endtask

  function automatic uart_status_t idle_status();
    uart_status_t s;
    s = '0;
    s.tx_empty = 1'b1;
    return s;
  endfunction

  // ------------------------------
  // Wishbone master
  // ------------------------------
  task automatic wait_ack();
    int cycles;
    cycles = 0;
    do begin
      wait_clocks(1);
      cycles++;
      if (cycles > WB_TIMEOUT) begin
        $display("Wishbone cycle was not acknowledged within %0d clocks", WB_TIMEOUT);
        report_failure();
      end
    end while (!wb_rsp.ack);
  endtask

  task automatic wb_write(input uart_addr_e addr, input uart_reg_word_u word);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: word};
    wait_ack();
    wb_req = '0;
  endtask

  task automatic wb_read(input uart_addr_e addr, output uart_reg_word_u word);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 32'd0};
    wait_ack();
    word = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic set_ctrl(input logic parity, input logic [15:0] div);
    uart_reg_word_u word;
    word = '0;
    word.ctrl_view.ctrl.parity_enable = parity;
    word.ctrl_view.ctrl.divisor = div;
    wb_write(CTRL, word);
    cur_parity = parity;
    bit_clocks = ((div < 16'd2) ? 2 : int'(div)) * `UART_OVERSAMPLE;
  endtask

  task automatic random_ctrl(input logic force_parity);
    logic [31:0] r;
    r = next_random();
    set_ctrl(r[0] | force_parity, 16'(2 + int'(r[3:2])));
  endtask

  task automatic write_byte(input uart_byte_t data);
    uart_reg_word_u word;
    word = '0;
    word.data_view.data = data;
    wb_write(DATA, word);
    exp_q.push_back(data);
  endtask

  // ------------------------------
  // Serial line models
  // ------------------------------
  initial begin : line_monitor
    uart_byte_t data;
    logic       par;
    wait (reset == 1'b0);
    forever begin
      wait_clocks(1);
      if (tx_line == 1'b0) begin
        wait_clocks(bit_clocks / 2);
        if (tx_line !== 1'b0) begin
          $display("Start bit on tx did not stay low until mid-bit");
          report_failure();
        end
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
          wait_clocks(bit_clocks);
          data[i] = tx_line;
        end
        if (cur_parity) begin
          wait_clocks(bit_clocks);
          par = tx_line;
          // Data ones plus the parity bit must come out odd.
          if ((^{data, par}) !== 1'b1) begin
            $display("Parity bit on tx does not make the count of ones odd");
            report_failure();
          end
        end
        wait_clocks(bit_clocks);
        if (tx_line !== 1'b1) begin
          $display("Stop bit on tx was not high");
          report_failure();
        end
        mon_q.push_back(data);
      end
    end
  end

  task automatic drive_bit(input logic b);
    rx_line = b;
    wait_clocks(bit_clocks);
  endtask

  task automatic send_frame(input uart_byte_t data, input logic flip_parity,
                            input logic low_stop);
    drive_bit(1'b0);
    for (int i = 0; i < `UART_DATA_BITS; i++) begin
      drive_bit(data[i]);
    end
    if (cur_parity) begin
      drive_bit((~^data) ^ flip_parity);
    end
    drive_bit(!low_stop);
    rx_line = 1'b1;
    wait_clocks(2 * bit_clocks);
  endtask

  task automatic wait_for_chars(input int n);
    int cycles;
    int limit;
    cycles = 0;
    limit = n * 14 * bit_clocks + 100;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("Only %0d of %0d characters appeared on tx", mon_q.size(), n);
        report_failure();
      end
    end while (mon_q.size() < n);
    #1;
  endtask

  task automatic compare_chars(input string name);
    uart_byte_t exp;
    uart_byte_t act;
    wait_for_chars(exp_q.size());
    while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      act = mon_q.pop_front();
      check_byte(name, exp, act);
    end
    if (mon_q.size() != 0) begin
      $display("More characters appeared on tx than were written");
      report_failure();
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset();
    uart_reg_word_u word;
    uart_ctrl_t     exp_ctrl;
    repeat (64) begin
      wait_clocks(1);
      if (tx_line !== 1'b1) begin
        $display("tx did not stay high after reset");
        report_failure();
      end
    end
    wb_read(STATUS, word);
    check_status("reset status", idle_status(), word.status_view.status);
    exp_ctrl.parity_enable = 1'b0;
    exp_ctrl.divisor = 16'(`UART_DIV_RESET);
    wb_read(CTRL, word);
    check_ctrl("reset ctrl", exp_ctrl, word.ctrl_view.ctrl);
  endtask

  task automatic test_ctrl();
    uart_reg_word_u word;
    uart_ctrl_t     exp_ctrl;
    logic [31:0]    r;
    repeat (6) begin
      r = next_random();
      exp_ctrl.parity_enable = r[16];
      exp_ctrl.divisor = r[15:0];
      set_ctrl(exp_ctrl.parity_enable, exp_ctrl.divisor);
      wb_read(CTRL, word);
      check_ctrl("ctrl round trip", exp_ctrl, word.ctrl_view.ctrl);
    end
  endtask

  task automatic test_transmit();
    int pass;
    pass = 0;
    repeat (2) begin
      // The second pass always sends a parity bit.
      random_ctrl(pass == 1);
      repeat (TX_FRAMES / 2) begin
        write_byte(uart_byte_t'(next_random()));
      end
      compare_chars("transmit");
      wait_clocks(2 * bit_clocks);
      pass++;
    end
  endtask

  task automatic test_backpressure();
    uart_reg_word_u word;
    uart_status_t   exp;
    random_ctrl(1'b0);
    repeat (BURST_LEN) begin
      write_byte(uart_byte_t'(next_random()));
    end
    compare_chars("backpressure");
    // The last frame is still in its stop bit, so the transmitter is busy.
    exp = idle_status();
    exp.tx_busy = 1'b1;
    wb_read(STATUS, word);
    check_status("backpressure status", exp, word.status_view.status);
    wait_clocks(2 * bit_clocks);
  endtask

  task automatic rx_case(input string name, input uart_byte_t data, input logic flip_parity,
                         input logic low_stop);
    uart_reg_word_u word;
    uart_status_t   exp;
    send_frame(data, flip_parity, low_stop);
    exp = idle_status();
    exp.rx_valid = 1'b1;
    exp.rx_parity_error = cur_parity && flip_parity;
    exp.rx_frame_error = low_stop;
    wb_read(STATUS, word);
    check_status(name, exp, word.status_view.status);
    wb_read(DATA, word);
    check_byte(name, data, word.data_view.data);
    wb_read(STATUS, word);
    check_status({name, " after read"}, idle_status(), word.status_view.status);
  endtask

  task automatic test_receive();
    random_ctrl(1'b0);
    repeat (RX_FRAMES - 4) begin
      rx_case("receive", uart_byte_t'(next_random()), 1'b0, 1'b0);
    end
    random_ctrl(1'b1);
    rx_case("parity error", uart_byte_t'(next_random()), 1'b1, 1'b0);
    rx_case("frame error", uart_byte_t'(next_random()), 1'b0, 1'b1);
  endtask

  task automatic test_overrun();
    uart_reg_word_u word;
    uart_status_t   exp;
    uart_byte_t     first;
    uart_byte_t     second;
    first = uart_byte_t'(next_random());
    second = uart_byte_t'(next_random());
    send_frame(first, 1'b0, 1'b0);
    send_frame(second, 1'b0, 1'b0);
    exp = idle_status();
    exp.rx_valid = 1'b1;
    exp.rx_overrun = 1'b1;
    wb_read(STATUS, word);
    check_status("overrun", exp, word.status_view.status);
    wb_read(DATA, word);
    check_byte("overrun", second, word.data_view.data);
    wb_read(STATUS, word);
    check_status("overrun after read", idle_status(), word.status_view.status);
  endtask

  initial begin : watchdog
    #(WD_CLOCKS * CLK_PERIOD);
    $display("Simulation did not finish within %0d clocks", WD_CLOCKS);
    report_failure();
  end

  initial begin : main
    wb_req = '0;
    rx_line = 1'b1;
    cur_parity = 1'b0;
    bit_clocks = `UART_DIV_RESET * `UART_OVERSAMPLE;
    wait (reset == 1'b0);
    test_reset();
    test_ctrl();
    test_transmit();
    test_backpressure();
    test_receive();
    test_overrun();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset drops just after a rising edge, like every other input.
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

//--- hdl/uart_top.sv
`include "uart_cfg.svh"

module uart_top
  import uart_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp,
  input  logic    rx,
  output logic    tx
);

  logic       push;
  uart_byte_t push_data;
  logic       fifo_full;
  logic       fifo_empty;
  logic       fifo_valid;
  uart_byte_t fifo_data;
  logic       tx_ready;
  logic       tx_busy;
  logic       tx_done;
  uart_ctrl_t ctrl;
  logic       ctrl_write;
  logic       sample_tick;
  logic       baud_tick;
  logic       frame_valid;
  rx_frame_t  rx_frame;

  uart_wb_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .push       (push),
    .push_data  (push_data),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .tx_busy    (tx_busy || tx_done),
    .frame_valid(frame_valid),
    .rx_frame   (rx_frame),
    .ctrl       (ctrl),
    .ctrl_write (ctrl_write)
  );

  uart_fifo #(
    .DEPTH(`UART_FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .push_data(push_data),
    .full     (fifo_full),
    .empty    (fifo_empty),
    .ready    (tx_ready),
    .valid    (fifo_valid),
    .pop_data (fifo_data)
  );

  uart_baud_gen u_baud_gen (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .restart    (ctrl_write),
    .sample_tick(sample_tick),
    .baud_tick  (baud_tick)
  );

  // The FIFO's valid doubles as the send request, and the pop happens on the latch edge.
  uart_tx #(
    .DATA_BITS(`UART_DATA_BITS)
  ) u_tx (
    .clk          (clk),
    .reset        (reset),
    .baud_tick    (baud_tick),
    .send_request (fifo_valid),
    .tx_data      (fifo_data),
    .parity_enable(ctrl.parity_enable),
    .ready        (tx_ready),
    .tx_pin       (tx),
    .tx_busy      (tx_busy),
    .tx_done      (tx_done)
  );

  uart_rx #(
    .DATA_BITS(`UART_DATA_BITS)
  ) u_rx (
    .clk          (clk),
    .reset        (reset),
    .sample_tick  (sample_tick),
    .parity_enable(ctrl.parity_enable),
    .rx_pin       (rx),
    .frame_valid  (frame_valid),
    .rx_frame     (rx_frame)
  );

endmodule

//--- hdl/uart_rx.sv
`include "uart_cfg.svh"

module uart_rx
  import uart_pkg::*;
#(
  parameter int DATA_BITS = 8
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      sample_tick,
  input  logic      parity_enable,
  input  logic      rx_pin,
  output logic      frame_valid,
  output rx_frame_t rx_frame
);

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
  } rx_state_e;

  localparam int OS = `UART_OVERSAMPLE;
  localparam int CW = $clog2(OS);
  localparam int IW = (DATA_BITS > 1) ? $clog2(DATA_BITS) : 1;

  rx_state_e            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_last;
  logic [CW-1:0]        sample_cnt;
  logic [IW-1:0]        bit_index;
  logic [DATA_BITS-1:0] shift;
  logic                 parity_error;
  logic                 mid_bit;

  // Sixteen samples after the middle of one bit is the middle of the next.
  assign mid_bit = (sample_cnt == CW'(OS - 1));

  // ------------------------------
  // Synchronizer
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_pin;
      rx_sync <= rx_meta;
    end
  end

  // ------------------------------
  // Frame FSM
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= IDLE;
      rx_last      <= 1'b1;
      sample_cnt   <= '0;
      bit_index    <= '0;
      shift        <= '0;
      parity_error <= 1'b0;
      frame_valid  <= 1'b0;
      rx_frame     <= '0;
    end else begin
      frame_valid <= 1'b0;
      if (sample_tick) begin
        rx_last <= rx_sync;
        case (state)
          IDLE: begin
            // Only a falling edge starts a frame, so a held low line is not re-read.
            if (!rx_sync && rx_last) begin
              sample_cnt <= '0;
              state      <= START;
            end
          end
          START: begin
            if (sample_cnt == CW'(OS / 2 - 1)) begin
              sample_cnt <= '0;
              if (!rx_sync) begin
                bit_index    <= '0;
                parity_error <= 1'b0;
                state        <= DATA;
              end else begin
                state <= IDLE;
              end
            end else begin
              sample_cnt <= sample_cnt + 1'b1;
            end
          end
          DATA: begin
            if (mid_bit) begin
              sample_cnt <= '0;
              shift      <= {rx_sync, shift[DATA_BITS-1:1]};
              if (bit_index == IW'(DATA_BITS - 1)) begin
                state <= parity_enable ? PARITY : STOP;
              end else begin
                bit_index <= bit_index + 1'b1;
              end
            end else begin
              sample_cnt <= sample_cnt + 1'b1;
            end
          end
          PARITY: begin
            if (mid_bit) begin
              sample_cnt   <= '0;
              parity_error <= ~(^shift ^ rx_sync);
              state        <= STOP;
            end else begin
              sample_cnt <= sample_cnt + 1'b1;
            end
          end
          STOP: begin
            if (mid_bit) begin
              sample_cnt  <= '0;
              frame_valid <= 1'b1;
              rx_frame    <= '{data: shift, parity_error: parity_error, frame_error: !rx_sync};
              state       <= IDLE;
            end else begin
              sample_cnt <= sample_cnt + 1'b1;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

endmodule

//--- hdl/uart_tx.sv
module uart_tx
  import uart_pkg::*;
#(
  parameter int DATA_BITS = 8
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       baud_tick,
  input  logic       send_request,
  input  uart_byte_t tx_data,
  input  logic       parity_enable,
  output logic       ready,
  output logic       tx_pin,
  output logic       tx_busy,
  output logic       tx_done
);

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    ODD_PARITY,
    STOP,
    DONE
  } tx_state_e;

  localparam int IW = (DATA_BITS > 1) ? $clog2(DATA_BITS) : 1;

  tx_state_e            state;
  logic [IW-1:0]        bit_index;
  logic [DATA_BITS-1:0] shift;

  assign ready = (state == IDLE);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      tx_pin    <= 1'b1;
      tx_busy   <= 1'b0;
      tx_done   <= 1'b0;
      bit_index <= '0;
      shift     <= '1;
    end else begin
      case (state)
        IDLE: begin
          tx_done <= 1'b0;
          tx_busy <= 1'b0;
          tx_pin  <= 1'b1;
          if (send_request) begin
            shift   <= tx_data;
            tx_busy <= 1'b1;
            state   <= START;
          end
        end
        default: begin
          // Every bit after the latch starts on a baud tick.
          if (baud_tick) begin
            case (state)
              START: begin
                tx_pin    <= 1'b0;
                bit_index <= '0;
                state     <= DATA;
              end
              DATA: begin
                tx_pin <= shift[bit_index];
                if (bit_index == IW'(DATA_BITS - 1)) begin
                  state <= parity_enable ? ODD_PARITY : STOP;
                end else begin
                  bit_index <= bit_index + 1'b1;
                end
              end
              ODD_PARITY: begin
                // Makes the number of ones across data and parity odd.
                tx_pin <= ~^shift;
                state  <= STOP;
              end
              STOP: begin
                tx_pin <= 1'b1;
                state  <= DONE;
              end
              DONE: begin
                tx_done <= 1'b1;
                tx_busy <= 1'b0;
                state   <= IDLE;
              end
              default: state <= IDLE;
            endcase
          end
        end
      endcase
    end
  end

endmodule

//--- hdl/uart_baud_gen.sv
`include "uart_cfg.svh"

module uart_baud_gen
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  uart_ctrl_t ctrl,
  input  logic       restart,
  output logic       sample_tick,
  output logic       baud_tick
);

  localparam int OS_W = $clog2(`UART_OVERSAMPLE);

  logic [15:0]     div_eff;
  logic [15:0]     div_cnt;
  logic [OS_W-1:0] os_cnt;

  // Divisors of 0 and 1 run at the fastest supported rate.
  assign div_eff = (ctrl.divisor < 16'd2) ? 16'd2 : ctrl.divisor;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_cnt     <= '0;
      os_cnt      <= '0;
      sample_tick <= 1'b0;
      baud_tick   <= 1'b0;
    end else if (restart) begin
      div_cnt     <= '0;
      os_cnt      <= '0;
      sample_tick <= 1'b0;
      baud_tick   <= 1'b0;
    end else begin
      sample_tick <= 1'b0;
      baud_tick   <= 1'b0;
      if (div_cnt >= div_eff - 16'd1) begin
        div_cnt     <= '0;
        sample_tick <= 1'b1;
        if (os_cnt == OS_W'(`UART_OVERSAMPLE - 1)) begin
          os_cnt    <= '0;
          baud_tick <= 1'b1;
        end else begin
          os_cnt <= os_cnt + 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 16'd1;
      end
    end
  end

endmodule

//--- hdl/uart_fifo.sv
module uart_fifo
  import uart_pkg::*;
#(
  parameter int DEPTH = 8
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       push,
  input  uart_byte_t push_data,
  output logic       full,
  output logic       empty,
  input  logic       ready,
  output logic       valid,
  output uart_byte_t pop_data
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  uart_byte_t    mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);
  assign valid    = !empty;
  assign pop_data = mem[rd_ptr];
  assign do_push  = push && !full;
  assign do_pop   = valid && ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged.
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- hdl/uart_wb_regs.sv
`include "uart_cfg.svh"

module uart_wb_regs
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  output logic       push,
  output uart_byte_t push_data,
  input  logic       fifo_full,
  input  logic       fifo_empty,
  input  logic       tx_busy,
  input  logic       frame_valid,
  input  rx_frame_t  rx_frame,
  output uart_ctrl_t ctrl,
  output logic       ctrl_write
);

  uart_reg_word_u wr_word;
  uart_reg_word_u rd_word;
  uart_status_t   status;
  logic           ack;
  logic [31:0]    rd_dat;
  logic           req;
  logic           wait_full;
  logic           accept;
  logic           data_read;

  uart_byte_t rx_data;
  logic       rx_valid;
  logic       rx_parity_error;
  logic       rx_frame_error;
  logic       rx_overrun;

  // ------------------------------
  // Bus handshake
  // ------------------------------
  assign wr_word = wb_req.dat;

  // The request is ignored while ack is high, since stb is still up in that cycle.
  assign req       = wb_req.cyc && wb_req.stb && !ack;
  assign wait_full = wb_req.we && (wb_req.adr == DATA) && fifo_full;
  assign accept    = req && !wait_full;
  assign push      = accept && wb_req.we && (wb_req.adr == DATA);
  assign push_data = wr_word.data_view.data;
  assign data_read = accept && !wb_req.we && (wb_req.adr == DATA);

  assign status = '{
    tx_full:         fifo_full,
    tx_empty:        fifo_empty,
    tx_busy:         tx_busy,
    rx_valid:        rx_valid,
    rx_parity_error: rx_parity_error,
    rx_frame_error:  rx_frame_error,
    rx_overrun:      rx_overrun
  };

  always_comb begin
    rd_word = '0;
    case (wb_req.adr)
      DATA:    rd_word.data_view.data = rx_data;
      CTRL:    rd_word.ctrl_view.ctrl = ctrl;
      STATUS:  rd_word.status_view.status = status;
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack                <= 1'b0;
      ctrl_write         <= 1'b0;
      ctrl.parity_enable <= 1'b0;
      ctrl.divisor       <= 16'(`UART_DIV_RESET);
    end else begin
      ack        <= accept;
      ctrl_write <= 1'b0;
      if (accept && wb_req.we && (wb_req.adr == CTRL)) begin
        ctrl       <= wr_word.ctrl_view.ctrl;
        ctrl_write <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Receive holding register
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rx_valid        <= 1'b0;
      rx_parity_error <= 1'b0;
      rx_frame_error  <= 1'b0;
      rx_overrun      <= 1'b0;
    end else if (frame_valid) begin
      // A new frame wins over a read in the same cycle.
      rx_valid        <= 1'b1;
      rx_parity_error <= (rx_parity_error && !data_read) || rx_frame.parity_error;
      rx_frame_error  <= (rx_frame_error && !data_read) || rx_frame.frame_error;
      rx_overrun      <= (rx_overrun && !data_read) || (rx_valid && !data_read);
    end else if (data_read) begin
      rx_valid        <= 1'b0;
      rx_parity_error <= 1'b0;
      rx_frame_error  <= 1'b0;
      rx_overrun      <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_valid) begin
      rx_data <= rx_frame.data;
    end
    if (accept) begin
      rd_dat <= wb_req.we ? 32'd0 : rd_word;
    end
  end

  assign wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

//--- hdl/uart_pkg.sv
`include "uart_cfg.svh"

package uart_pkg;

  typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

  typedef enum logic [1:0] {
    DATA   = 2'd0,
    CTRL   = 2'd1,
    STATUS = 2'd2
  } uart_addr_e;

  // ------------------------------
  // Wishbone bundles
  // ------------------------------
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    uart_addr_e  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // ------------------------------
  // Register contents
  // ------------------------------
  typedef struct packed {
    logic        parity_enable;
    logic [15:0] divisor;
  } uart_ctrl_t;

  typedef struct packed {
    logic tx_full;
    logic tx_empty;
    logic tx_busy;
    logic rx_valid;
    logic rx_parity_error;
    logic rx_frame_error;
    logic rx_overrun;
  } uart_status_t;

  typedef struct packed {
    uart_byte_t data;
    logic       parity_error;
    logic       frame_error;
  } rx_frame_t;

  typedef struct packed {
    logic [31-`UART_DATA_BITS:0] pad;
    uart_byte_t                  data;
  } uart_data_word_t;

  typedef struct packed {
    logic [14:0] pad;
    uart_ctrl_t  ctrl;
  } uart_ctrl_word_t;

  typedef struct packed {
    logic [24:0]  pad;
    uart_status_t status;
  } uart_status_word_t;

  // The same bus word, read according to the register address.
  typedef union packed {
    uart_data_word_t   data_view;
    uart_ctrl_word_t   ctrl_view;
    uart_status_word_t status_view;
  } uart_reg_word_u;

endpackage

//--- hdl/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Width of one character on the line.
`define UART_DATA_BITS 8

// Number of entries in the transmit FIFO.
`define UART_FIFO_DEPTH 8

// Sample ticks per bit time, used by both the receiver and the baud generator.
`define UART_OVERSAMPLE 16

// Clocks per sample tick after reset.
`define UART_DIV_RESET 2

`endif
